// ==== test/rvstep_stimulus.txt ====
20000093 00000100 00000001 00000200 00000104 00000000
12345137 00000104 00000002 12345000 00000108 00000000
67810113 00000108 00000002 12345678 0000010c 00000000
00001197 0000010c 00000003 0000110c 00000110 00000000
ffb00213 00000110 00000004 fffffffb 00000114 00000000
404102b3 00000114 00000005 1234567d 00000118 00000000
40125313 00000118 00000006 fffffffd 0000011c 00000000
00500013 0000011c 00000000 00000000 00000120 00000000
003003b3 00000120 00000007 0000110c 00000124 00000000
00222433 00000124 00000008 00000001 00000128 00000000
0020a023 00000128 00000000 00000000 0000012c 00000000
00409323 0000012c 00000000 00000000 00000130 00000000
004084a3 00000130 00000000 00000000 00000134 00000000
0000a483 00000134 00000009 12345678 00000138 00000000
00609503 00000138 0000000a fffffffb 0000013c 00000000
0060d583 0000013c 0000000b 0000fffb 00000140 00000000
00908603 00000140 0000000c fffffffb 00000144 00000000
0090c683 00000144 0000000d 000000fb 00000148 00000000
00308703 00000148 0000000e 00000012 0000014c 00000000
00248463 0000014c 00000000 00000000 00000154 00000000
00001863 00000154 00000000 00000000 00000158 00000000
fe024ce3 00000158 00000000 00000000 00000150 00000000
020007ef 00000150 0000000f 00000154 00000170 00000000
00538867 00000170 00000010 00000174 00001110 00000000
00180893 00001110 00000011 00000175 00001114 00000000
022106b3 00001114 00000000 00000000 00000000 00000001
0020a483 00000000 00000000 00000000 00000000 00000001
00000073 00000000 00000000 00000000 00000000 00000001
00d489b3 00000000 00000013 12345773 00000004 00000000
fff9ca13 00000004 00000014 edcba88c 00000008 00000000

// ==== rvstep.f ====
common/rvstep_pkg.sv
exec/insn_decoder.sv
exec/step_exec.sv
design/regfile.sv
design/axil_data_port.sv
design/step_ctrl.sv
design/rvstep_top.sv
test/axil_mem_model.sv
test/tb_rvstep.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the rvstep testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_rvstep -Mdir obj_dir -f rvstep.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_rvstep > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see $LOG"
exit 1

// ==== test/tb_rvstep.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rvstep import rvstep_pkg::*; ();

	localparam logic [31:0] RESET_PC = 32'h0000_0100;
	localparam int TIMEOUT = 200;

	typedef struct packed {
		logic [31:0] insn;
		logic [31:0] pc;
		logic [31:0] rd;
		logic [31:0] rd_wdata;
		logic [31:0] next_pc;
		logic [31:0] trap;
	} stim_entry_t;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        insn_valid;
	logic        insn_ready;
	insn_t       insn;
	logic        retire_valid;
	logic        retire_ready;
	retire_t     retire;
	logic        awvalid;
	logic        awready;
	logic [31:0] awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	logic [31:0] araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic [31:0] lfsr;
	stim_entry_t stim [$];

	always #2 clk = ~clk;

	rvstep_top #(
		.RESET_PC(RESET_PC)
	) i_rvstep_top (
		.clk(clk), .rst_n(rst_n),
		.insn_valid(insn_valid), .insn_ready(insn_ready), .insn(insn),
		.retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

	axil_mem_model #(
		.SEED(32'h13fb_98a6)
	) i_axil_mem_model (
		.clk(clk),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

	// galois lfsr for x^32 + x^22 + x^2 + x + 1 that steps once per bit.
	function automatic logic next_random_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	task automatic check_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else abort_run($sformatf("[ERROR] %0d ns: %s expected %08h, actual %08h",
			$time, name, expected, actual));
	endtask

	task automatic load_stimulus();
		int          fd;
		int          code;
		logic [31:0] f_insn;
		logic [31:0] f_pc;
		logic [31:0] f_rd;
		logic [31:0] f_wdata;
		logic [31:0] f_next;
		logic [31:0] f_trap;
		fd = $fopen("test/rvstep_stimulus.txt", "r");
		assert (fd != 0) else abort_run("cannot open test/rvstep_stimulus.txt");
		code = $fscanf(fd, "%h %h %h %h %h %h", f_insn, f_pc, f_rd, f_wdata, f_next, f_trap);
		while (code == 6) begin
			stim.push_back({f_insn, f_pc, f_rd, f_wdata, f_next, f_trap});
			code = $fscanf(fd, "%h %h %h %h %h %h", f_insn, f_pc, f_rd, f_wdata, f_next, f_trap);
		end
		$fclose(fd);
		assert (stim.size() > 0) else abort_run("the stimulus file holds no instructions");
	endtask

	// entered and left 1 ns after a rising edge.
	task automatic send_insn(input logic [31:0] word);
		int   cycles;
		logic accepted;
		cycles = 0;
		insn_valid = 1'b1;
		insn = word;
		do begin
			@(negedge clk);
			check_field("retire_valid before acceptance", 32'd0, {31'b0, retire_valid});
			accepted = insn_ready;
			@(posedge clk);
			#1;
			retire_ready = next_random_bit();
			cycles++;
			assert (accepted || cycles < TIMEOUT)
			else abort_run("insn_ready did not rise within 200 cycles");
		end while (!accepted);
		insn_valid = 1'b0;
		insn = '0;
	endtask

	task automatic collect_retire(input stim_entry_t e, input logic [31:0] prev_next);
		int      cycles;
		int      first_cycle;
		logic    done;
		logic    mem_access;
		retire_t held;
		cycles = 0;
		first_cycle = -1;
		done = 1'b0;
		mem_access = (e.insn[6:0] == opc_load || e.insn[6:0] == opc_store) && !e.trap[0];
		do begin
			@(negedge clk);
			if (retire_valid && first_cycle < 0) begin
				first_cycle = cycles;
				held = retire;
			end
			if (retire_valid && retire_ready) begin
				assert (retire === held)
				else abort_run("the retire record changed while retire_ready was low");
				check_field("retire.pc", e.pc, retire.pc);
				check_field("retire.pc against previous next_pc", prev_next, retire.pc);
				check_field("retire.insn", e.insn, retire.insn);
				check_field("retire.rd", e.rd, {27'b0, retire.rd});
				check_field("retire.rd_wdata", e.rd_wdata, retire.rd_wdata);
				check_field("retire.next_pc", e.next_pc, retire.next_pc);
				check_field("retire.trap", e.trap, {31'b0, retire.trap});
				if (!mem_access)
					check_field("retire latency in cycles", 32'd1, first_cycle);
				done = 1'b1;
			end
			@(posedge clk);
			#1;
			retire_ready = next_random_bit();
			cycles++;
			assert (done || cycles < TIMEOUT)
			else abort_run("no retire handshake within 200 cycles");
		end while (!done);
	endtask

	initial begin
		logic [31:0] prev_next;
		lfsr = 32'h13fb_98a6;
		rst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		retire_ready = 1'b0;
		load_stimulus();
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_field("insn_ready after reset", 32'd1, {31'b0, insn_ready});
		check_field("retire_valid after reset", 32'd0, {31'b0, retire_valid});
		check_field("axi valids after reset", 32'd0, {29'b0, awvalid, wvalid, arvalid});
		@(posedge clk);
		#1;
		prev_next = RESET_PC;   // the first retire must report the reset pc.
		foreach (stim[i]) begin
			send_insn(stim[i].insn);
			collect_retire(stim[i], prev_next);
			prev_next = stim[i].next_pc;
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/axil_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_mem_model #(
	parameter logic [31:0] SEED = 32'h13fb_98a6
) (
	input  logic        clk,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	input  logic        arvalid,
	output logic        arready,
	input  logic [31:0] araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp
);

	logic [31:0] mem [0:255];   // 1 KB of words with the upper address bits ignored.
	logic [31:0] lfsr;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;
	logic [3:0]  wr_strb;
	logic [31:0] rd_addr;
	logic        have_aw;
	logic        have_w;
	logic        have_ar;
	logic        b_done;
	logic        r_done;

	function automatic logic next_random_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	initial begin
		lfsr = SEED;
		for (int i = 0; i < 256; i++)
			mem[i] = {8'hc3, i[7:0], ~i[7:0], i[7:0] ^ 8'h5a};
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = 2'b00;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		have_aw = 1'b0;
		have_w = 1'b0;
		have_ar = 1'b0;
		forever begin
			// both sides of a channel are stable half a cycle before the edge that completes it.
			@(negedge clk);
			if (awvalid && awready) begin
				wr_addr = awaddr;
				have_aw = 1'b1;
			end
			if (wvalid && wready) begin
				wr_data = wdata;
				wr_strb = wstrb;
				have_w = 1'b1;
			end
			if (arvalid && arready) begin
				rd_addr = araddr;
				have_ar = 1'b1;
			end
			b_done = bvalid && bready;
			r_done = rvalid && rready;
			@(posedge clk);
			#1;
			if (b_done)
				bvalid = 1'b0;
			if (r_done)
				rvalid = 1'b0;
			if (have_aw && have_w && next_random_bit()) begin
				for (int b = 0; b < 4; b++)
					if (wr_strb[b])
						mem[wr_addr[9:2]][8*b +: 8] = wr_data[8*b +: 8];
				bvalid = 1'b1;
				have_aw = 1'b0;
				have_w = 1'b0;
			end
			if (have_ar && next_random_bit()) begin
				rdata = mem[rd_addr[9:2]];
				rvalid = 1'b1;
				have_ar = 1'b0;
			end
			awready = !have_aw && next_random_bit();
			wready = !have_w && next_random_bit();
			arready = !have_ar && next_random_bit();
		end
	end

endmodule

`default_nettype wire

// ==== design/rvstep_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvstep_top import rvstep_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        insn_valid,
	output logic        insn_ready,
	input  insn_t       insn,
	output logic        retire_valid,
	input  logic        retire_ready,
	output retire_t     retire,
	output logic        awvalid,
	input  logic        awready,
	output logic [31:0] awaddr,
	output logic        wvalid,
	input  logic        wready,
	output logic [31:0] wdata,
	output logic [3:0]  wstrb,
	input  logic        bvalid,
	output logic        bready,
	input  logic [1:0]  bresp,
	output logic        arvalid,
	input  logic        arready,
	output logic [31:0] araddr,
	input  logic        rvalid,
	output logic        rready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp
);

	insn_t        insn_q;
	decoded_t     dec;
	step_result_t result;
	logic [31:0]  pc;
	logic [31:0]  rs1_data;
	logic [31:0]  rs2_data;
	logic [31:0]  load_word;
	logic         mem_start;
	logic         mem_done;
	logic         mem_err;
	logic         rf_we;
	logic [4:0]   rf_rd;
	logic [31:0]  rf_wdata;

	step_ctrl #(
		.RESET_PC(RESET_PC)
	) i_step_ctrl (
		.clk(clk), .rst_n(rst_n),
		.insn_valid(insn_valid), .insn_ready(insn_ready), .insn(insn),
		.retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire),
		.insn_q(insn_q), .pc(pc), .result(result),
		.mem_start(mem_start), .mem_done(mem_done), .mem_err(mem_err),
		.rf_we(rf_we), .rf_rd(rf_rd), .rf_wdata(rf_wdata)
	);

	insn_decoder i_insn_decoder (
		.insn(insn_q),
		.dec(dec)
	);

	regfile i_regfile (
		.clk(clk),
		.rs1(dec.rs1), .rs2(dec.rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.we(rf_we), .rd(rf_rd), .wdata(rf_wdata)
	);

	step_exec i_step_exec (
		.dec(dec), .pc(pc),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.load_word(load_word), .load_err(mem_err),
		.result(result)
	);

	axil_data_port i_axil_data_port (
		.clk(clk), .rst_n(rst_n),
		.start(mem_start), .req(result.mem),
		.done(mem_done), .rdata_word(load_word), .err(mem_err),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

endmodule

`default_nettype wire

// ==== design/step_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module step_ctrl import rvstep_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         insn_valid,
	output logic         insn_ready,
	input  insn_t        insn,
	output logic         retire_valid,
	input  logic         retire_ready,
	output retire_t      retire,
	output insn_t        insn_q,
	output logic [31:0]  pc,
	input  step_result_t result,
	output logic         mem_start,
	input  logic         mem_done,
	input  logic         mem_err,
	output logic         rf_we,
	output logic [4:0]   rf_rd,
	output logic [31:0]  rf_wdata
);

	typedef enum logic [1:0] {
		st_idle,
		st_exec,
		st_mem_wait,
		st_retire
	} ctrl_state_e;

	ctrl_state_e state;
	logic        mem_needed;
	logic        capture;
	logic        fault;
	logic        rec_we;

	assign mem_needed   = result.mem.rd_en || result.mem.wr_en;
	assign mem_start    = state == st_exec && mem_needed;
	assign fault        = mem_done && mem_err;   // a bus error turns the step into a trap.
	assign capture      = (state == st_exec && !mem_needed) || (state == st_mem_wait && mem_done);
	assign insn_ready   = state == st_idle;
	assign retire_valid = state == st_retire;
	assign rf_we        = retire_valid && retire_ready && rec_we;
	assign rf_rd        = retire.rd;
	assign rf_wdata     = retire.rd_wdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			pc    <= RESET_PC;
		end else begin
			case (state)
				st_idle: if (insn_valid) state <= st_exec;
				st_exec: state <= mem_needed ? st_mem_wait : st_retire;
				st_mem_wait: if (mem_done) state <= st_retire;
				default: begin
					if (retire_ready) begin
						pc    <= retire.next_pc;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (insn_valid && insn_ready)
			insn_q <= insn;
		if (capture) begin
			retire.pc       <= pc;
			retire.insn     <= insn_q;
			retire.rd       <= fault ? 5'd0 : result.rd;
			retire.rd_wdata <= fault ? 32'd0 : result.rd_wdata;
			retire.next_pc  <= fault ? 32'd0 : result.next_pc;
			retire.trap     <= result.trap || fault;
			rec_we          <= result.rd_we && !fault;
		end
	end

	a_retire_stable: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire));

endmodule

`default_nettype wire

// ==== design/axil_data_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_data_port import rvstep_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  mem_req_t    req,
	output logic        done,
	output logic [31:0] rdata_word,
	output logic        err,
	output logic        awvalid,
	input  logic        awready,
	output logic [31:0] awaddr,
	output logic        wvalid,
	input  logic        wready,
	output logic [31:0] wdata,
	output logic [3:0]  wstrb,
	input  logic        bvalid,
	output logic        bready,
	input  logic [1:0]  bresp,
	output logic        arvalid,
	input  logic        arready,
	output logic [31:0] araddr,
	input  logic        rvalid,
	output logic        rready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp
);

	typedef enum logic [1:0] {
		st_idle,
		st_write,
		st_read
	} port_state_e;

	port_state_e state;

	assign bready = state == st_write;
	assign rready = state == st_read;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= st_idle;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			arvalid <= 1'b0;
			done    <= 1'b0;
			err     <= 1'b0;
		end else begin
			done <= 1'b0;
			err  <= 1'b0;   // err is only meaningful in the cycle done is high.
			case (state)
				st_idle: begin
					if (start && req.wr_en) begin
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
						state   <= st_write;
					end else if (start && req.rd_en) begin
						arvalid <= 1'b1;
						state   <= st_read;
					end
				end
				st_write: begin
					if (awready)
						awvalid <= 1'b0;
					if (wready)
						wvalid <= 1'b0;
					if (bvalid) begin
						done  <= 1'b1;
						err   <= bresp != axil_resp_okay;
						state <= st_idle;
					end
				end
				st_read: begin
					if (arready)
						arvalid <= 1'b0;
					if (rvalid) begin
						done  <= 1'b1;
						err   <= rresp != axil_resp_okay;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			awaddr <= req.addr;
			araddr <= req.addr;
			wdata  <= req.wdata;
			wstrb  <= req.strb;
		end
		if (rvalid && rready)
			rdata_word <= rdata;
	end

	property p_valid_hold(valid, ready);
		@(posedge clk) disable iff (!rst_n) valid && !ready |=> valid;
	endproperty

	a_aw_hold: assert property (p_valid_hold(awvalid, awready));
	a_w_hold: assert property (p_valid_hold(wvalid, wready));
	a_ar_hold: assert property (p_valid_hold(arvalid, arready));

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile (
	input  logic        clk,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	output logic [31:0] rs1_data,
	output logic [31:0] rs2_data,
	input  logic        we,
	input  logic [4:0]  rd,
	input  logic [31:0] wdata
);

	logic [31:0] regs [1:31];   // x0 has no storage.

	assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (we && rd != 5'd0)
			regs[rd] <= wdata;
	end

endmodule

`default_nettype wire

// ==== exec/step_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

module step_exec import rvstep_pkg::*; (
	input  decoded_t     dec,
	input  logic [31:0]  pc,
	input  logic [31:0]  rs1_data,
	input  logic [31:0]  rs2_data,
	input  logic [31:0]  load_word,
	input  logic         load_err,
	output step_result_t result
);

	logic [31:0] op_b;
	logic [31:0] alu_out;
	logic [31:0] pc_plus4;
	logic [31:0] pc_rel;
	logic [31:0] mem_addr;
	logic [4:0]  byte_sh;
	logic [31:0] ld_shifted;
	logic [31:0] ld_value;
	logic [31:0] rd_value;
	logic [31:0] target;
	logic [3:0]  strb;
	logic        taken;
	logic        is_jump;
	logic        is_load;
	logic        is_store;
	logic        mem_misaligned;
	logic        trap;
	logic        rd_we;

	assign op_b     = (dec.op_class == alu_reg) ? rs2_data : dec.imm;
	assign pc_plus4 = pc + 32'd4;
	assign pc_rel   = pc + dec.imm;
	assign mem_addr = rs1_data + dec.imm;   // also the jalr target before bit 0 is cleared.
	assign byte_sh  = {mem_addr[1:0], 3'b000};
	assign is_load  = dec.op_class == load;
	assign is_store = dec.op_class == store;

	always_comb begin
		case (dec.funct3)
			3'b000: alu_out = (dec.op_class == alu_reg && dec.funct7_5) ?
				rs1_data - op_b : rs1_data + op_b;
			3'b001: alu_out = rs1_data << op_b[4:0];
			3'b010: alu_out = {31'b0, $signed(rs1_data) < $signed(op_b)};
			3'b011: alu_out = {31'b0, rs1_data < op_b};
			3'b100: alu_out = rs1_data ^ op_b;
			3'b101: begin
				if (dec.funct7_5)
					alu_out = $signed(rs1_data) >>> op_b[4:0];
				else
					alu_out = rs1_data >> op_b[4:0];
			end
			3'b110: alu_out = rs1_data | op_b;
			default: alu_out = rs1_data & op_b;
		endcase

		case (dec.funct3)
			3'b000: taken = rs1_data == rs2_data;
			3'b001: taken = rs1_data != rs2_data;
			3'b100: taken = $signed(rs1_data) < $signed(rs2_data);
			3'b101: taken = $signed(rs1_data) >= $signed(rs2_data);
			3'b110: taken = rs1_data < rs2_data;
			default: taken = rs1_data >= rs2_data;
		endcase
	end

	always_comb begin
		target  = pc_plus4;
		is_jump = dec.op_class == jal || dec.op_class == jalr || (dec.op_class == branch && taken);
		if (dec.op_class == jalr)
			target = {mem_addr[31:1], 1'b0};
		else if (is_jump)
			target = pc_rel;

		// byte and half accesses are shifted into their lane of the aligned word.
		case (dec.funct3[1:0])
			2'b00: strb = 4'b0001 << mem_addr[1:0];
			2'b01: strb = 4'b0011 << mem_addr[1:0];
			default: strb = 4'b1111;
		endcase
		mem_misaligned = (is_load || is_store) &&
			((dec.funct3[1:0] == 2'b01 && mem_addr[0]) ||
			(dec.funct3[1:0] == 2'b10 && mem_addr[1:0] != 2'b00));

		ld_shifted = load_word >> byte_sh;
		case (dec.funct3)
			3'b000: ld_value = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
			3'b001: ld_value = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
			3'b100: ld_value = {24'b0, ld_shifted[7:0]};
			3'b101: ld_value = {16'b0, ld_shifted[15:0]};
			default: ld_value = ld_shifted;
		endcase

		case (dec.op_class)
			lui: rd_value = dec.imm;
			auipc: rd_value = pc_rel;
			jal, jalr: rd_value = pc_plus4;
			load: rd_value = ld_value;
			default: rd_value = alu_out;
		endcase
	end

	assign trap  = dec.illegal || mem_misaligned || load_err ||
		(is_jump && target[1:0] != 2'b00);
	assign rd_we = !trap && dec.rd != 5'd0 && dec.op_class != branch && !is_store;

	always_comb begin
		result.trap       = trap;
		result.next_pc    = trap ? 32'd0 : target;
		result.rd_we      = rd_we;
		result.rd         = rd_we ? dec.rd : 5'd0;
		result.rd_wdata   = rd_we ? rd_value : 32'd0;
		result.mem.rd_en  = is_load && !trap;
		result.mem.wr_en  = is_store && !trap;
		result.mem.addr   = {mem_addr[31:2], 2'b00};
		result.mem.wdata  = rs2_data << byte_sh;
		result.mem.strb   = strb;
	end

endmodule

`default_nettype wire

// ==== exec/insn_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module insn_decoder import rvstep_pkg::*; (
	input  insn_t    insn,
	output decoded_t dec
);

	always_comb begin
		// register fields sit at the same bits in every format that has them.
		dec.funct3   = insn.r.funct3;
		dec.funct7_5 = insn.r.funct7[5];
		dec.rs1      = insn.r.rs1;
		dec.rs2      = insn.r.rs2;
		dec.rd       = insn.r.rd;
		dec.op_class = alu_imm;
		dec.imm      = {{20{insn.i.imm[11]}}, insn.i.imm};
		dec.illegal  = 1'b0;

		case (insn.r.opcode)
			opc_reg: begin
				dec.op_class = alu_reg;
				if (insn.r.funct7 == 7'b0100000)
					dec.illegal = !(insn.r.funct3 == 3'b000 || insn.r.funct3 == 3'b101);
				else if (insn.r.funct7 != 7'b0000000)
					dec.illegal = 1'b1;
			end
			opc_imm: begin
				dec.op_class = alu_imm;
				if (insn.i.funct3 == 3'b001)
					dec.illegal = insn.r.funct7 != 7'b0000000;
				else if (insn.i.funct3 == 3'b101)
					dec.illegal = insn.r.funct7 != 7'b0000000 && insn.r.funct7 != 7'b0100000;
			end
			opc_lui: begin
				dec.op_class = lui;
				dec.imm = {insn.u.imm, 12'b0};
			end
			opc_auipc: begin
				dec.op_class = auipc;
				dec.imm = {insn.u.imm, 12'b0};
			end
			opc_jal: begin
				dec.op_class = jal;
				dec.imm = {{12{insn.j.imm20}}, insn.j.imm19_12, insn.j.imm11,
					insn.j.imm10_1, 1'b0};
			end
			opc_jalr: begin
				dec.op_class = jalr;
				dec.illegal = insn.i.funct3 != 3'b000;
			end
			opc_branch: begin
				dec.op_class = branch;
				dec.imm = {{20{insn.b.imm12}}, insn.b.imm11, insn.b.imm10_5,
					insn.b.imm4_1, 1'b0};
				dec.illegal = insn.b.funct3[2:1] == 2'b01;   // funct3 010 and 011 are unused.
			end
			opc_load: begin
				dec.op_class = load;
				dec.illegal = insn.i.funct3 == 3'b011 || insn.i.funct3[2:1] == 2'b11;
			end
			opc_store: begin
				dec.op_class = store;
				dec.imm = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
				dec.illegal = insn.s.funct3[2] || insn.s.funct3[1:0] == 2'b11;
			end
			default: dec.illegal = 1'b1;   // fence, system and anything outside rv32i.
		endcase
	end

endmodule

`default_nettype wire

// ==== common/rvstep_pkg.sv ====
`default_nettype none

package rvstep_pkg;

	// base opcodes of RV32I that the step unit executes.
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_imm    = 7'b0010011;
	localparam logic [6:0] opc_reg    = 7'b0110011;

	localparam logic [1:0] axil_resp_okay = 2'b00;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, seen through each of the six base formats.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} insn_t;

	typedef enum logic [3:0] {
		alu_reg,
		alu_imm,
		lui,
		auipc,
		jal,
		jalr,
		branch,
		load,
		store
	} op_class_e;

	typedef struct packed {
		op_class_e   op_class;
		logic [2:0]  funct3;
		logic        funct7_5;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [31:0] imm;
		logic        illegal;
	} decoded_t;

	typedef struct packed {
		logic        rd_en;
		logic        wr_en;
		logic [31:0] addr;   // word aligned.
		logic [31:0] wdata;
		logic [3:0]  strb;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] next_pc;
		logic [4:0]  rd;
		logic [31:0] rd_wdata;
		logic        rd_we;
		mem_req_t    mem;
		logic        trap;
	} step_result_t;

	typedef struct packed {
		logic [31:0] pc;
		insn_t       insn;
		logic [4:0]  rd;
		logic [31:0] rd_wdata;
		logic [31:0] next_pc;
		logic        trap;
	} retire_t;

endpackage

`default_nettype wire
